// File: bank_array.sv
// SDIM simple dual-port banks, two pages each
// All banks share the write address, each bank has its own read address
`timescale 1ns/100ps
`include "tp_config.svh"

module bank_array import stream_pkg::*, bank_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_en,
	input  bank_addr_t wr_addr,
	input  beat_t      bank_data,
	input  bank_addr_t bank_rd_addr [`TP_SDIM],
	input  logic       rd_hold,
	output beat_t      bank_q
);

	for (genvar b = 0; b < `TP_SDIM; b++) begin : gen_bank
		elem_t mem [`TP_BANK_DEPTH];
		elem_t q_r;

		// Write port
		always_ff @(posedge clk) begin
			if (wr_en) begin
				mem[wr_addr] <= bank_data[b];
			end
		end

		// Registered read, frozen while the output path stalls
		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				q_r <= '0;
			end else if (!rd_hold) begin
				q_r <= mem[bank_rd_addr[b]];
			end
		end

		assign bank_q[b] = q_r;
	end

endmodule

// File: bank_pkg.sv
// Bank storage types
// Address top half is page B when TP_BANK_DEPTH is a power of two
`include "tp_config.svh"

package bank_pkg;

	// Bank number, doubles as lane number
	typedef logic [$clog2(`TP_SDIM)-1:0] bank_idx_t;

	// Word address inside one bank, both pages
	typedef logic [$clog2(`TP_BANK_DEPTH)-1:0] bank_addr_t;

	// Page select for ping-pong operation
	typedef enum logic {
		PAGE_A,
		PAGE_B
	} page_e;

	// ------------------------------
	// Read loop counters
	// ------------------------------
	typedef logic [$clog2(`TP_I)-1:0] row_idx_t;
	typedef logic [$clog2(`TP_J)-1:0] col_idx_t;

endpackage

// File: bank_read_map.sv
// Column-order read addresses and output lane reordering
// rd_row is always a multiple of SDIM, so lane k sees row rd_row+k
`timescale 1ns/100ps
`include "tp_config.svh"

module bank_read_map import stream_pkg::*, bank_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       rd_en,
	input  page_e      rd_page,
	input  row_idx_t   rd_row,
	input  col_idx_t   rd_col,
	output bank_addr_t bank_rd_addr [`TP_SDIM],
	input  beat_t      bank_q,
	output beat_t      rd_data
);

	// Bank that serves each output lane, now and one cycle later
	bank_idx_t lane_bank   [`TP_SDIM];
	bank_idx_t lane_bank_q [`TP_SDIM];

	// ------------------------------
	// Address generation
	// ------------------------------
	always_comb begin
		int unsigned row;
		int unsigned word;
		for (int k = 0; k < `TP_SDIM; k++) begin
			bank_rd_addr[k] = '0;
		end
		for (int k = 0; k < `TP_SDIM; k++) begin
			row = rd_row + k;
			// Same rule as the write side, bank (row + col) mod SDIM
			lane_bank[k] = bank_idx_t'(row + rd_col);
			word = (row * `TP_J + rd_col) / `TP_SDIM;
			if (rd_page == PAGE_B) begin
				word = word + `TP_PAGE_WORDS;
			end
			bank_rd_addr[lane_bank[k]] = bank_addr_t'(word);
		end
	end

	// Pattern travels alongside the bank read
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_bank_q <= '{default: '0};
		end else if (rd_en) begin
			lane_bank_q <= lane_bank;
		end
	end

	// ------------------------------
	// Output reordering
	// ------------------------------
	always_comb begin
		for (int k = 0; k < `TP_SDIM; k++) begin
			rd_data[k] = bank_q[lane_bank_q[k]];
		end
	end

endmodule

// File: bank_write_map.sv
// Input lane to bank steering, rotated by one bank per input row
// Needs J to be a multiple of SDIM so that a row never splits a beat
`timescale 1ns/100ps
`include "tp_config.svh"

module bank_write_map import stream_pkg::*, bank_pkg::*; (
	input  bank_addr_t wr_addr,
	input  beat_t      in_data,
	output beat_t      bank_data
);

	bank_addr_t page_addr;
	bank_idx_t  row_rot;

	// Word offset inside the current page
	assign page_addr = (wr_addr >= bank_addr_t'(`TP_PAGE_WORDS)) ?
		wr_addr - bank_addr_t'(`TP_PAGE_WORDS) : wr_addr;

	// Input row modulo SDIM
	assign row_rot = bank_idx_t'(page_addr / `TP_ROW_BEATS);

	// Lane c goes to bank (c + row) mod SDIM
	always_comb begin
		bank_data = '0;
		for (int c = 0; c < `TP_SDIM; c++) begin
			bank_data[bank_idx_t'(c) + row_rot] = in_data[c];
		end
	end

endmodule

// File: project.f
+incdir+.
stream_pkg.sv
bank_pkg.sv
transpose_ctrl.sv
bank_write_map.sv
bank_array.sv
bank_read_map.sv
skid_buffer.sv
ptranspose.sv
ptranspose_sva.sv
ptranspose_tb.sv

// File: ptranspose.sv
// Streaming transpose, I x J in by rows, out by columns, SDIM elements per beat
// Two pages let one job be read while the next is written
`timescale 1ns/100ps
`include "tp_config.svh"

module ptranspose import stream_pkg::*, bank_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  in_valid,
	input  beat_t in_data,
	output logic  in_ready,
	output logic  out_valid,
	output beat_t out_data,
	input  logic  out_ready
);

	// Write path
	logic       wr_en;
	bank_addr_t wr_addr;
	beat_t      bank_data;

	// Read path
	logic       rd_ready;
	logic       rd_en;
	logic       rd_vld;
	page_e      rd_page;
	row_idx_t   rd_row;
	col_idx_t   rd_col;
	bank_addr_t bank_rd_addr [`TP_SDIM];
	beat_t      bank_q;
	beat_t      rd_data;

	// ------------------------------
	// Control
	// ------------------------------
	transpose_ctrl transpose_ctrl_inst (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.rd_ready (rd_ready),
		.rd_en    (rd_en),
		.rd_vld   (rd_vld),
		.rd_page  (rd_page),
		.rd_row   (rd_row),
		.rd_col   (rd_col)
	);

	// ------------------------------
	// Datapath
	// ------------------------------
	bank_write_map bank_write_map_inst (
		.wr_addr   (wr_addr),
		.in_data   (in_data),
		.bank_data (bank_data)
	);

	// Bank outputs freeze whenever the skid refuses a new read
	bank_array bank_array_inst (
		.clk          (clk),
		.rst          (rst),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.bank_data    (bank_data),
		.bank_rd_addr (bank_rd_addr),
		.rd_hold      (!rd_ready),
		.bank_q       (bank_q)
	);

	bank_read_map bank_read_map_inst (
		.clk          (clk),
		.rst          (rst),
		.rd_en        (rd_en),
		.rd_page      (rd_page),
		.rd_row       (rd_row),
		.rd_col       (rd_col),
		.bank_rd_addr (bank_rd_addr),
		.bank_q       (bank_q),
		.rd_data      (rd_data)
	);

	skid_buffer skid_buffer_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (rd_vld),
		.in_data   (rd_data),
		.in_ready  (rd_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

endmodule

// File: ptranspose_sva.sv
// Handshake and reset checks on the transpose top level
// Stored jobs are counted from the port handshakes, one job per page of beats
`timescale 1ns/100ps
`include "tp_config.svh"

module ptranspose_sva import stream_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  in_valid,
	input logic  in_ready,
	input logic  out_valid,
	input beat_t out_data,
	input logic  out_ready
);

	localparam int JOB_BEATS = `TP_PAGE_WORDS;

	// Number of failed assertions
	int fail_count = 0;

	// Beats taken in and handed out since reset
	int in_beats;
	int out_beats;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_beats  <= 0;
			out_beats <= 0;
		end else begin
			if (in_valid && in_ready) begin
				in_beats <= in_beats + 1;
			end
			if (out_valid && out_ready) begin
				out_beats <= out_beats + 1;
			end
		end
	end

	// A stalled output beat stays put until taken
	out_stable_a: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else begin
			fail_count = fail_count + 1;
			$error("out_valid or out_data changed while the output was stalled");
		end

	// Nothing leaves in the first cycle out of reset
	reset_idle_a: assert property (@(posedge clk) $fell(rst) |-> !out_valid)
		else begin
			fail_count = fail_count + 1;
			$error("out_valid high in the first cycle after reset");
		end

	// Input stalls only while two whole jobs wait to be delivered
	in_ready_a: assert property (@(posedge clk) disable iff (rst)
		!in_ready |-> ((in_beats / JOB_BEATS) - (out_beats / JOB_BEATS)) >= 2)
		else begin
			fail_count = fail_count + 1;
			$error("in_ready low while a page is empty");
		end

endmodule

bind ptranspose ptranspose_sva ptranspose_sva_inst (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_data  (out_data),
	.out_ready (out_ready)
);

// File: ptranspose_tb.sv
// Table-driven testbench for the transpose unit, inputs change on the falling edge
// Expected beats come from a transpose model of each generated input matrix
`timescale 1ns/100ps
`include "tp_config.svh"

module ptranspose_tb import stream_pkg::*; ();

	localparam int JOB_BEATS = `TP_PAGE_WORDS;
	localparam int TIMEOUT   = 200;
	localparam int NUM_JOBS  = 7;

	// Table row: seed mixed into the elements, input gaps, output stalls
	typedef struct packed {
		logic [7:0] seed;
		logic       gaps;
		logic       stalls;
	} job_row_t;

	logic  clk;
	logic  rst;
	logic  in_valid;
	beat_t in_data;
	logic  in_ready;
	logic  out_valid;
	beat_t out_data;
	logic  out_ready;

	logic [31:0] lfsr;
	job_row_t    job_table [NUM_JOBS];
	beat_t       in_q [$];
	beat_t       exp_q [$];
	int          gap_len [$];
	int          stall_len [$];

	ptranspose ptranspose_inst (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// Random source and checks
	// ------------------------------
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_random_bit()};
		end
		return v;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_beat(input string name, input beat_t got, input beat_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			report_failure("output beat does not match the transpose model");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			report_failure("control signal has the wrong level");
		end
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------
	task automatic build_job(input job_row_t row);
		elem_t mat [`TP_I][`TP_J];
		beat_t b;
		int    i;
		int    j;
		for (int r = 0; r < `TP_I; r++) begin
			for (int c = 0; c < `TP_J; c++) begin
				mat[r][c] = elem_t'(random_bits(`TP_BITS) ^ row.seed);
			end
		end
		// Input goes row by row, SDIM columns per beat
		for (int n = 0; n < JOB_BEATS; n++) begin
			for (int k = 0; k < `TP_SDIM; k++) begin
				b[k] = mat[n / `TP_ROW_BEATS][(n % `TP_ROW_BEATS) * `TP_SDIM + k];
			end
			in_q.push_back(b);
			gap_len.push_back(row.gaps ? int'(random_bits(2)) : 0);
		end
		// Output beat n is column n/COL_BEATS, rows from SDIM*(n mod COL_BEATS)
		for (int n = 0; n < JOB_BEATS; n++) begin
			j = n / `TP_COL_BEATS;
			i = `TP_SDIM * (n % `TP_COL_BEATS);
			for (int k = 0; k < `TP_SDIM; k++) begin
				b[k] = mat[i + k][j];
			end
			exp_q.push_back(b);
			stall_len.push_back(row.stalls ? int'(random_bits(2)) : 0);
		end
	endtask

	task automatic clear_queues();
		in_q.delete();
		exp_q.delete();
		gap_len.delete();
		stall_len.delete();
	endtask

	// ------------------------------
	// Stream drivers
	// ------------------------------
	task automatic drive_input();
		int wait_cnt;
		for (int n = 0; n < in_q.size(); n++) begin
			for (int g = 0; g < gap_len[n]; g++) begin
				@(negedge clk);
				in_valid = 1'b0;
			end
			@(negedge clk);
			in_valid = 1'b1;
			in_data  = in_q[n];
			wait_cnt = 0;
			// in_ready comes from registers only, stable until the next rising edge
			while (!in_ready) begin
				wait_cnt++;
				if (wait_cnt > TIMEOUT) begin
					report_failure("input beat was not accepted before the timeout");
				end
				@(negedge clk);
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic collect_output();
		int wait_cnt;
		int count;
		count = exp_q.size();
		for (int n = 0; n < count; n++) begin
			for (int s = 0; s < stall_len[n]; s++) begin
				@(negedge clk);
				out_ready = 1'b0;
			end
			@(negedge clk);
			out_ready = 1'b1;
			wait_cnt  = 0;
			while (!out_valid) begin
				wait_cnt++;
				if (wait_cnt > TIMEOUT) begin
					report_failure("expected output beat did not arrive before the timeout");
				end
				@(negedge clk);
			end
			check_beat("out_data", out_data, exp_q.pop_front());
		end
	endtask

	// Jobs of the table rows first..last, streamed back to back
	task automatic run_jobs(input int first, input int last);
		clear_queues();
		for (int t = first; t <= last; t++) begin
			build_job(job_table[t]);
		end
		fork
			drive_input();
			collect_output();
		join
		// No extra beat may follow the last expected one
		for (int c = 0; c < 4; c++) begin
			@(negedge clk);
			check_flag("out_valid", out_valid, 1'b0);
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		lfsr      = 32'hb262_aede;
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_data   = '0;
		out_ready = 1'b0;
		job_table[0] = {8'h00, 1'b0, 1'b0};
		job_table[1] = {8'h5a, 1'b0, 1'b0};
		job_table[2] = {8'hc3, 1'b0, 1'b0};
		job_table[3] = {8'h0f, 1'b0, 1'b0};
		job_table[4] = {8'h96, 1'b1, 1'b0};
		job_table[5] = {8'h21, 1'b0, 1'b1};
		job_table[6] = {8'he7, 1'b1, 1'b1};

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);

		// Single job, then back to back jobs, then gaps and stalls
		run_jobs(0, 0);
		run_jobs(1, 3);
		run_jobs(4, NUM_JOBS - 1);

		// Output blocked, two jobs fill both pages
		clear_queues();
		out_ready = 1'b0;
		build_job(job_table[1]);
		build_job(job_table[2]);
		drive_input();
		// A third job may not start while both pages are full
		in_valid = 1'b1;
		in_data  = '1;
		for (int c = 0; c < 20; c++) begin
			check_flag("in_ready", in_ready, 1'b0);
			@(negedge clk);
		end
		in_valid = 1'b0;
		collect_output();
		@(negedge clk);
		check_flag("in_ready", in_ready, 1'b1);

		if (ptranspose_inst.ptranspose_sva_inst.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_failure("bound assertions reported errors during the run");
		end
	end

endmodule

// File: skid_buffer.sv
// One-entry register stage between the bank read pipeline and the output
// in_ready grants the next read; a presented beat is never refused
`timescale 1ns/100ps

module skid_buffer import stream_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  in_valid,
	input  beat_t in_data,
	output logic  in_ready,
	output logic  out_valid,
	output beat_t out_data,
	input  logic  out_ready
);

	beat_t buf_data;
	logic  buf_valid;
	logic  buf_load;

	// Stored beat goes out first
	assign out_valid = buf_valid || in_valid;
	assign out_data  = buf_valid ? buf_data : in_data;

	// Room for a beat next cycle only if nothing gets parked now
	assign in_ready = !buf_valid && (out_ready || !in_valid);

	// Park the incoming beat when downstream stalls
	assign buf_load = !buf_valid && in_valid && !out_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			buf_valid <= 1'b0;
		end else if (buf_valid && out_ready) begin
			buf_valid <= 1'b0;
		end else if (buf_load) begin
			buf_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (buf_load) begin
			buf_data <= in_data;
		end
	end

endmodule

// File: stream_pkg.sv
// Stream payload types, shared by both sides of the transpose unit
// A beat carries SDIM elements, lane 0 in the low bits
`include "tp_config.svh"

package stream_pkg;

	// One matrix element
	typedef logic [`TP_BITS-1:0] elem_t;

	// One beat of the stream
	// Lane k holds the element of column j+k on input
	// and of row i+k on output
	typedef elem_t [`TP_SDIM-1:0] beat_t;

endpackage

// File: tp_config.svh
// Sizes of one transpose job and of the bank storage
// I and J must be multiples of SDIM and SDIM must be a power of two
`ifndef TP_CONFIG_SVH
`define TP_CONFIG_SVH

// Width of one element in bits
`define TP_BITS 8

// Job shape, rows by columns
`define TP_I 8
`define TP_J 8

// Elements per beat, also the number of banks
`define TP_SDIM 4

// ------------------------------
// Derived sizes
// ------------------------------
`define TP_ROW_BEATS (`TP_J / `TP_SDIM)
`define TP_COL_BEATS (`TP_I / `TP_SDIM)

// One page holds one whole job, spread over all banks
`define TP_PAGE_WORDS (`TP_I * `TP_J / `TP_SDIM)
`define TP_BANK_DEPTH (2 * `TP_PAGE_WORDS)

`endif

// File: transpose_ctrl.sv
// Write pointer over both pages, page-full tracking, column-order read loop
// A page is read only once it is completely written
`timescale 1ns/100ps
`include "tp_config.svh"

module transpose_ctrl import bank_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	output logic       in_ready,
	output logic       wr_en,
	output bank_addr_t wr_addr,
	input  logic       rd_ready,
	output logic       rd_en,
	output logic       rd_vld,
	output page_e      rd_page,
	output row_idx_t   rd_row,
	output col_idx_t   rd_col
);

	// Bit 0 is page A, bit 1 is page B
	logic [1:0] page_full;
	logic       col_end;
	logic       rd_last;

	// ------------------------------
	// Write side
	// ------------------------------
	// Stall input only when no page is free
	assign in_ready = !(page_full[0] && page_full[1]);
	assign wr_en    = in_valid && in_ready;

	// Sequential address, wraps after page B
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_addr <= '0;
		end else if (wr_en) begin
			if (wr_addr == bank_addr_t'(`TP_BANK_DEPTH - 1)) begin
				wr_addr <= '0;
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	// Set by the last write of a page, cleared by its last read
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			page_full <= 2'b00;
		end else begin
			if (wr_en && wr_addr == bank_addr_t'(`TP_PAGE_WORDS - 1)) begin
				page_full[0] <= 1'b1;
			end
			if (wr_en && wr_addr == bank_addr_t'(`TP_BANK_DEPTH - 1)) begin
				page_full[1] <= 1'b1;
			end
			if (rd_en && rd_last) begin
				page_full[rd_page] <= 1'b0;
			end
		end
	end

	// ------------------------------
	// Read side
	// ------------------------------
	// One output beat per cycle while the page is full and the skid has room
	assign rd_en = page_full[rd_page] && rd_ready;

	// Last row group of a column, and last beat of the page
	assign col_end = (rd_row == row_idx_t'((`TP_COL_BEATS - 1) * `TP_SDIM));
	assign rd_last = col_end && (rd_col == col_idx_t'(`TP_J - 1));

	// Outer loop over columns, inner loop over row groups
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_row  <= '0;
			rd_col  <= '0;
			rd_page <= PAGE_A;
			rd_vld  <= 1'b0;
		end else begin
			// Bank data lags the read by one cycle
			rd_vld <= rd_en;
			if (rd_en) begin
				if (col_end) begin
					rd_row <= '0;
					if (rd_last) begin
						rd_col  <= '0;
						rd_page <= (rd_page == PAGE_A) ? PAGE_B : PAGE_A;
					end else begin
						rd_col <= rd_col + 1'b1;
					end
				end else begin
					rd_row <= rd_row + row_idx_t'(`TP_SDIM);
				end
			end
		end
	end

endmodule
